// ==== src/avr_io_consts.svh ====
`ifndef AVR_IO_CONSTS_SVH
`define AVR_IO_CONSTS_SVH

`define AVR_ADDR_W      12
`define AVR_DATA_W      8
`define AVR_N_SLAVES    7

// DDR at PIN+1 and PORT at PIN+2
`define AVR_PINB_ADR    12'h023
`define AVR_PINC_ADR    12'h026
`define AVR_PIND_ADR    12'h029
`define AVR_PINE_ADR    12'h02C
`define AVR_PORTB_W     8
`define AVR_PORTC_W     7
`define AVR_PORTD_W     8
`define AVR_PORTE_W     4

`define AVR_TIFR0_ADR   12'h035
`define AVR_EIFR_ADR    12'h03C
`define AVR_EIMSK_ADR   12'h03D
`define AVR_EICRA_ADR   12'h069
`define AVR_TIMSK0_ADR  12'h06E

`define AVR_GTCCR_ADR   12'h043
`define AVR_TCCR0A_ADR  12'h044
`define AVR_TCCR0B_ADR  12'h045
`define AVR_TCNT0_ADR   12'h046
`define AVR_OCR0A_ADR   12'h047

`define AVR_TOV0_BIT    0
`define AVR_OCF0A_BIT   1
`define AVR_PSRSYNC_BIT 0

`define AVR_VEC_INT0     6'd1
`define AVR_VEC_INT1     6'd2
`define AVR_VEC_T0_COMPA 6'd14
`define AVR_VEC_T0_OVF   6'd16
`define AVR_VEC_W        6

`endif

// ==== src/avr_io_pkg.sv ====
`include "avr_io_consts.svh"

package avr_io_pkg;

	// Single-cycle register access from the bus bridge
	typedef struct packed {
		logic                   we;
		logic                   re;
		logic [`AVR_ADDR_W-1:0] adr;
		logic [`AVR_DATA_W-1:0] wdat;
	} io_req_t;

	typedef struct packed {
		logic                   hit;  // Address belongs to this block
		logic [`AVR_DATA_W-1:0] rdat;
	} io_rsp_t;

	typedef io_rsp_t [`AVR_N_SLAVES-1:0] io_rsp_vec_t;

	// Sized for the widest port with unused upper bits at 0
	typedef struct packed {
		logic [`AVR_DATA_W-1:0] dir;
		logic [`AVR_DATA_W-1:0] val;
		logic [`AVR_DATA_W-1:0] pu;
	} port_pads_t;

endpackage

// ==== src/io_bus_bridge.sv ====
`timescale 1ns/1ps
`include "avr_io_consts.svh"

module io_bus_bridge import avr_io_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	input  logic [`AVR_ADDR_W-1:0] wb_adr_i,
	input  logic [`AVR_DATA_W-1:0] wb_dat_i,
	input  io_rsp_vec_t            rsp_i,
	output logic                   wb_ack_o,
	output logic [`AVR_DATA_W-1:0] wb_dat_o,
	output io_req_t                req_o
);

	logic                     access;
	logic [`AVR_DATA_W-1:0]   rd_data;
	logic [`AVR_N_SLAVES-1:0] hits;

	assign access     = wb_cyc_i & wb_stb_i & ~wb_ack_o; // Open until ack
	assign req_o.we   = access & wb_we_i;
	assign req_o.re   = access & ~wb_we_i;
	assign req_o.adr  = wb_adr_i;
	assign req_o.wdat = wb_dat_i;

	// Walk downwards so the lowest index hit wins
	always_comb begin
		rd_data = '0;
		for (int i = `AVR_N_SLAVES - 1; i >= 0; i--) begin
			hits[i] = rsp_i[i].hit;
			if (rsp_i[i].hit)
				rd_data = rsp_i[i].rdat;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= access;
	end

	always_ff @(posedge clk) begin
		if (req_o.re)
			wb_dat_o <= rd_data;
	end

	// Each register address belongs to at most one block
	a_decode_unique: assert property (@(posedge clk) disable iff (!rst_n_i)
		access |-> $onehot0(hits));

endmodule

// ==== src/gpio_port.sv ====
`timescale 1ns/1ps
`include "avr_io_consts.svh"

module gpio_port import avr_io_pkg::*; #(
	parameter int                     WIDTH   = `AVR_PORTB_W,
	parameter logic [`AVR_ADDR_W-1:0] PIN_ADR = `AVR_PINB_ADR
) (
	input  logic             clk,
	input  logic             rst_n_i,
	input  io_req_t          req_i,
	input  logic [WIDTH-1:0] pin_i,
	output io_rsp_t          rsp_o,
	output port_pads_t       pads_o,
	output logic [WIDTH-1:0] pin_sync_o
);

	localparam logic [`AVR_ADDR_W-1:0] DDR_ADR  = PIN_ADR + 12'd1;
	localparam logic [`AVR_ADDR_W-1:0] PORT_ADR = PIN_ADR + 12'd2;

	logic [WIDTH-1:0] ddr_q;
	logic [WIDTH-1:0] port_q;
	logic [WIDTH-1:0] pin_meta;
	logic [WIDTH-1:0] pin_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ddr_q    <= '0;
			port_q   <= '0;
			pin_meta <= '0;
			pin_q    <= '0;
		end else begin
			pin_meta <= pin_i; // Two-flop synchronizer
			pin_q    <= pin_meta;
			if (req_i.we && req_i.adr == DDR_ADR)
				ddr_q <= req_i.wdat[WIDTH-1:0];
			if (req_i.we && req_i.adr == PORT_ADR)
				port_q <= req_i.wdat[WIDTH-1:0];
			else if (req_i.we && req_i.adr == PIN_ADR)
				port_q <= port_q ^ req_i.wdat[WIDTH-1:0]; // Toggle on 1
		end
	end

	assign pin_sync_o = pin_q;
	assign pads_o.dir = 8'(ddr_q);
	assign pads_o.val = 8'(port_q);
	assign pads_o.pu  = 8'(port_q & ~ddr_q); // Pull-up only on inputs

	always_comb begin
		rsp_o.hit  = 1'b1;
		rsp_o.rdat = '0;
		case (req_i.adr)
			PIN_ADR:  rsp_o.rdat = 8'(pin_q);
			DDR_ADR:  rsp_o.rdat = 8'(ddr_q);
			PORT_ADR: rsp_o.rdat = 8'(port_q);
			default:  rsp_o.hit  = 1'b0;
		endcase
	end

endmodule

// ==== src/timer0_prescaler.sv ====
`timescale 1ns/1ps
`include "avr_io_consts.svh"

module timer0_prescaler import avr_io_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  io_req_t    req_i,
	input  logic [2:0] cs_i,
	output io_rsp_t    rsp_o,
	output logic       tick_o
);

	logic [9:0] pre_cnt;
	logic       psr_wr;

	assign psr_wr = req_i.we && req_i.adr == `AVR_GTCCR_ADR
		&& req_i.wdat[`AVR_PSRSYNC_BIT];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			pre_cnt <= '0;
		else if (psr_wr)
			pre_cnt <= '0;
		else
			pre_cnt <= pre_cnt + 10'd1;
	end

	// Tick on the last count of each tap
	always_comb begin
		case (cs_i)
			3'd1:    tick_o = 1'b1;
			3'd2:    tick_o = &pre_cnt[2:0];
			3'd3:    tick_o = &pre_cnt[5:0];
			3'd4:    tick_o = &pre_cnt[7:0];
			3'd5:    tick_o = &pre_cnt;
			default: tick_o = 1'b0; // Stopped, no external clock
		endcase
	end

	assign rsp_o.hit  = req_i.adr == `AVR_GTCCR_ADR;
	assign rsp_o.rdat = '0; // PSRSYNC self-clears

endmodule

// ==== src/timer0.sv ====
`timescale 1ns/1ps
`include "avr_io_consts.svh"

module timer0 import avr_io_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  io_req_t    req_i,
	input  logic       tick_i,
	input  logic       clr_compa_i,
	input  logic       clr_ovf_i,
	output io_rsp_t    rsp_o,
	output logic [2:0] cs_o,
	output logic       compa_irq_o,
	output logic       ovf_irq_o
);

	logic [1:0] wgm;   // TCCR0A WGM01:00 where only WGM01 acts
	logic [2:0] cs;
	logic [7:0] tcnt0;
	logic [7:0] ocr0a;
	logic [1:0] timsk0;
	logic [1:0] tifr0;
	logic       ctc, match, wr_tcnt, wr_ocr;
	logic [1:0] flag_set, flag_clr;

	assign ctc     = wgm[1];
	assign match   = tcnt0 == ocr0a;
	assign wr_tcnt = req_i.we && req_i.adr == `AVR_TCNT0_ADR;
	assign wr_ocr  = req_i.we && req_i.adr == `AVR_OCR0A_ADR;

	always_comb begin
		flag_set = '0;
		flag_clr = '0;
		flag_set[`AVR_TOV0_BIT]  = tick_i && tcnt0 == 8'hFF;
		flag_set[`AVR_OCF0A_BIT] = tick_i && match;
		if (req_i.we && req_i.adr == `AVR_TIFR0_ADR)
			flag_clr = req_i.wdat[1:0]; // Write 1 to clear
		flag_clr[`AVR_TOV0_BIT]  |= clr_ovf_i;
		flag_clr[`AVR_OCF0A_BIT] |= clr_compa_i;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wgm    <= '0;
			cs     <= '0;
			tcnt0  <= '0;
			ocr0a  <= '0;
			timsk0 <= '0;
			tifr0  <= '0;
		end else begin
			if (req_i.we && req_i.adr == `AVR_TCCR0A_ADR)
				wgm <= req_i.wdat[1:0];
			if (req_i.we && req_i.adr == `AVR_TCCR0B_ADR)
				cs <= req_i.wdat[2:0];
			if (req_i.we && req_i.adr == `AVR_TIMSK0_ADR)
				timsk0 <= req_i.wdat[1:0];
			if (wr_ocr)
				ocr0a <= req_i.wdat;
			if (wr_tcnt)
				tcnt0 <= req_i.wdat; // Bus write beats the tick
			else if (tick_i)
				tcnt0 <= (ctc && match) ? 8'h00 : tcnt0 + 8'd1;
			tifr0 <= (tifr0 & ~flag_clr) | flag_set; // Set wins
		end
	end

	assign cs_o        = cs;
	assign compa_irq_o = tifr0[`AVR_OCF0A_BIT] & timsk0[`AVR_OCF0A_BIT];
	assign ovf_irq_o   = tifr0[`AVR_TOV0_BIT] & timsk0[`AVR_TOV0_BIT];

	always_comb begin
		rsp_o.hit  = 1'b1;
		rsp_o.rdat = '0;
		case (req_i.adr)
			`AVR_TCCR0A_ADR: rsp_o.rdat = {6'b0, wgm};
			`AVR_TCCR0B_ADR: rsp_o.rdat = {5'b0, cs};
			`AVR_TCNT0_ADR:  rsp_o.rdat = tcnt0;
			`AVR_OCR0A_ADR:  rsp_o.rdat = ocr0a;
			`AVR_TIMSK0_ADR: rsp_o.rdat = {6'b0, timsk0};
			`AVR_TIFR0_ADR:  rsp_o.rdat = {6'b0, tifr0};
			default:         rsp_o.hit  = 1'b0;
		endcase
	end

	// CTC keeps the count at or below TOP unless software moves it
	a_ctc_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
		(ctc && tcnt0 <= ocr0a && !wr_tcnt && !wr_ocr) |=> (!ctc || tcnt0 <= ocr0a));

endmodule

// ==== src/ext_int.sv ====
`timescale 1ns/1ps
`include "avr_io_consts.svh"

module ext_int import avr_io_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  io_req_t    req_i,
	input  logic [1:0] int_pins_i,
	input  logic [1:0] clr_i,
	output io_rsp_t    rsp_o,
	output logic [1:0] irq_o
);

	logic [3:0] eicra;  // ISC11:10, ISC01:00
	logic [1:0] eimsk;
	logic [1:0] eifr;
	logic [1:0] pin_q;  // Last sampled pin level
	logic [1:0] edge_hit, level_req, flag_clr;

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			case (eicra[2*i +: 2])
				2'b01:   edge_hit[i] = int_pins_i[i] ^ pin_q[i];
				2'b10:   edge_hit[i] = ~int_pins_i[i] & pin_q[i];
				2'b11:   edge_hit[i] = int_pins_i[i] & ~pin_q[i];
				default: edge_hit[i] = 1'b0; // Level mode keeps no flag
			endcase
			level_req[i] = eicra[2*i +: 2] == 2'b00 && !int_pins_i[i];
		end
		flag_clr = clr_i;
		if (req_i.we && req_i.adr == `AVR_EIFR_ADR)
			flag_clr = flag_clr | req_i.wdat[1:0];
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			eicra <= '0;
			eimsk <= '0;
			eifr  <= '0;
			pin_q <= '0;
		end else begin
			pin_q <= int_pins_i;
			if (req_i.we && req_i.adr == `AVR_EICRA_ADR)
				eicra <= req_i.wdat[3:0];
			if (req_i.we && req_i.adr == `AVR_EIMSK_ADR)
				eimsk <= req_i.wdat[1:0];
			eifr <= (eifr & ~flag_clr) | edge_hit;
		end
	end

	assign irq_o = eimsk & (eifr | level_req);

	always_comb begin
		rsp_o.hit  = 1'b1;
		rsp_o.rdat = '0;
		case (req_i.adr)
			`AVR_EICRA_ADR: rsp_o.rdat = {4'b0, eicra};
			`AVR_EIMSK_ADR: rsp_o.rdat = {6'b0, eimsk};
			`AVR_EIFR_ADR:  rsp_o.rdat = {6'b0, eifr};
			default:        rsp_o.hit  = 1'b0;
		endcase
	end

endmodule

// ==== src/irq_vector_arb.sv ====
`timescale 1ns/1ps
`include "avr_io_consts.svh"

module irq_vector_arb import avr_io_pkg::*; (
	input  logic [3:0]            irq_i,  // INT0, INT1, T0 COMPA, T0 OVF
	input  logic                  irq_ack_i,
	output logic                  irq_req_o,
	output logic [`AVR_VEC_W-1:0] irq_vec_o,
	output logic [3:0]            clr_o
);

	logic [3:0] win;

	// Lower vector number wins
	always_comb begin
		win       = '0;
		irq_vec_o = '0;
		if (irq_i[0]) begin
			win[0]    = 1'b1;
			irq_vec_o = `AVR_VEC_INT0;
		end else if (irq_i[1]) begin
			win[1]    = 1'b1;
			irq_vec_o = `AVR_VEC_INT1;
		end else if (irq_i[2]) begin
			win[2]    = 1'b1;
			irq_vec_o = `AVR_VEC_T0_COMPA;
		end else if (irq_i[3]) begin
			win[3]    = 1'b1;
			irq_vec_o = `AVR_VEC_T0_OVF;
		end
	end

	assign irq_req_o = |irq_i;
	assign clr_o     = win & {4{irq_ack_i}};

	a_ack_pending: assert property (@(posedge irq_ack_i) irq_req_o);

endmodule

// ==== src/avr_io_top.sv ====
`timescale 1ns/1ps
`include "avr_io_consts.svh"

module avr_io_top import avr_io_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	input  logic                    wb_we_i,
	input  logic [`AVR_ADDR_W-1:0]  wb_adr_i,
	input  logic [`AVR_DATA_W-1:0]  wb_dat_i,
	output logic                    wb_ack_o,
	output logic [`AVR_DATA_W-1:0]  wb_dat_o,
	input  logic                    irq_ack_i,
	input  logic [`AVR_PORTB_W-1:0] pinb_i,
	input  logic [`AVR_PORTC_W-1:0] pinc_i,
	input  logic [`AVR_PORTD_W-1:0] pind_i,
	input  logic [`AVR_PORTE_W-1:0] pine_i,
	output port_pads_t              padsb_o,
	output port_pads_t              padsc_o,
	output port_pads_t              padsd_o,
	output port_pads_t              padse_o,
	output logic                    irq_req_o,
	output logic [`AVR_VEC_W-1:0]   irq_vec_o
);

	io_req_t                 req;
	io_rsp_vec_t             rsp;   // 0..3 ports B-E, 4 GTCCR, 5 timer0, 6 ext int
	logic [`AVR_PORTD_W-1:0] pind_sync;
	logic                    t0_tick;
	logic [2:0]              t0_cs;
	logic                    t0_compa_irq, t0_ovf_irq;
	logic [1:0]              ext_irq;
	logic [3:0]              irq_clr;

	io_bus_bridge bridge0 (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.rsp_i    (rsp),
		.wb_ack_o (wb_ack_o),
		.wb_dat_o (wb_dat_o),
		.req_o    (req)
	);

	gpio_port #(.WIDTH(`AVR_PORTB_W), .PIN_ADR(`AVR_PINB_ADR)) port_b (
		.clk(clk), .rst_n_i(rst_n_i), .req_i(req), .pin_i(pinb_i),
		.rsp_o(rsp[0]), .pads_o(padsb_o), .pin_sync_o()
	);

	gpio_port #(.WIDTH(`AVR_PORTC_W), .PIN_ADR(`AVR_PINC_ADR)) port_c (
		.clk(clk), .rst_n_i(rst_n_i), .req_i(req), .pin_i(pinc_i),
		.rsp_o(rsp[1]), .pads_o(padsc_o), .pin_sync_o()
	);

	// PD2 and PD3 double as INT0 and INT1
	gpio_port #(.WIDTH(`AVR_PORTD_W), .PIN_ADR(`AVR_PIND_ADR)) port_d (
		.clk(clk), .rst_n_i(rst_n_i), .req_i(req), .pin_i(pind_i),
		.rsp_o(rsp[2]), .pads_o(padsd_o), .pin_sync_o(pind_sync)
	);

	gpio_port #(.WIDTH(`AVR_PORTE_W), .PIN_ADR(`AVR_PINE_ADR)) port_e (
		.clk(clk), .rst_n_i(rst_n_i), .req_i(req), .pin_i(pine_i),
		.rsp_o(rsp[3]), .pads_o(padse_o), .pin_sync_o()
	);

	timer0_prescaler pres0 (
		.clk(clk), .rst_n_i(rst_n_i), .req_i(req), .cs_i(t0_cs),
		.rsp_o(rsp[4]), .tick_o(t0_tick)
	);

	timer0 tc0 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.req_i       (req),
		.tick_i      (t0_tick),
		.clr_compa_i (irq_clr[2]),
		.clr_ovf_i   (irq_clr[3]),
		.rsp_o       (rsp[5]),
		.cs_o        (t0_cs),
		.compa_irq_o (t0_compa_irq),
		.ovf_irq_o   (t0_ovf_irq)
	);

	ext_int exti0 (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.req_i      (req),
		.int_pins_i (pind_sync[3:2]),
		.clr_i      (irq_clr[1:0]),
		.rsp_o      (rsp[6]),
		.irq_o      (ext_irq)
	);

	irq_vector_arb arb0 (
		.irq_i     ({t0_ovf_irq, t0_compa_irq, ext_irq}),
		.irq_ack_i (irq_ack_i),
		.irq_req_o (irq_req_o),
		.irq_vec_o (irq_vec_o),
		.clr_o     (irq_clr)
	);

endmodule

// ==== verif/io_checker.sv ====
`timescale 1ns/1ps
`include "avr_io_consts.svh"

module io_checker import avr_io_pkg::*; (
	input  logic                   clk,
	input  logic                   wb_ack_i,
	input  logic [`AVR_DATA_W-1:0] wb_dat_i,
	input  logic                   irq_req_i,
	input  logic [`AVR_VEC_W-1:0]  irq_vec_i,
	input  port_pads_t             padsb_i,
	input  port_pads_t             padsc_i,
	input  port_pads_t             padsd_i,
	input  port_pads_t             padse_i
);

	int    pass_cnt = 0;
	int    fail_cnt = 0;
	bit    rd_pend  = 0;
	bit    rd_range = 0;
	string rd_name;
	int    rd_exp, rd_mask;  // Range reads use these as low and high

	task automatic expect_read(input string name, input int exp, input int mask);
		rd_name  = name;
		rd_exp   = exp;
		rd_mask  = mask;
		rd_range = 0;
		rd_pend  = 1;
	endtask

	task automatic expect_range(input string name, input int lo, input int hi);
		rd_name  = name;
		rd_exp   = lo;
		rd_mask  = hi;
		rd_range = 1;
		rd_pend  = 1;
	endtask

	task automatic compare(input string name, input int exp, input int act);
		if (exp == act) begin
			pass_cnt++;
			$display("PASS %s", name);
		end else begin
			fail_cnt++;
			$display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
		end
	endtask

	task automatic note_error(input string msg);
		fail_cnt++;
		$display("ERROR %s", msg);
	endtask

	// Read data is stable in the middle of the ack cycle
	always @(negedge clk) begin
		int act;
		if (rd_pend && wb_ack_i) begin
			rd_pend = 0;
			act     = int'(wb_dat_i);
			if (!rd_range)
				compare(rd_name, rd_exp & rd_mask, act & rd_mask);
			else if (act >= rd_exp && act <= rd_mask) begin
				pass_cnt++;
				$display("PASS %s", rd_name);
			end else begin
				fail_cnt++;
				$display("[FAIL] %s expected 0x%0h..0x%0h actual 0x%0h",
					rd_name, rd_exp, rd_mask, act);
			end
		end
	end

	task automatic check_irq(input string name, input int req, input int vec);
		int act;
		act = irq_req_i ? int'(irq_vec_i) : 0;
		compare({name, "_req"}, req, int'(irq_req_i));
		if (req != 0)
			compare({name, "_vec"}, vec, act);
	endtask

	task automatic check_pads(input string name, input int idx, input int exp);
		int act;
		case (idx)
			0:       act = int'(padsb_i);
			1:       act = int'(padsc_i);
			2:       act = int'(padsd_i);
			default: act = int'(padse_i);
		endcase
		compare(name, exp, act);
	endtask

	task automatic report();
		$display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
	endtask

endmodule

// ==== verif/tb_avr_io.sv ====
`timescale 1ns/1ps
`include "avr_io_consts.svh"

module tb_avr_io import avr_io_pkg::*; ();

	localparam int OP_WR   = 0;
	localparam int OP_RD   = 1;
	localparam int OP_RNG  = 2;  // Read checked against a range
	localparam int OP_PIN  = 3;
	localparam int OP_WAIT = 4;
	localparam int OP_ACK  = 5;
	localparam int OP_IRQ  = 6;
	localparam int OP_PAD  = 7;

	typedef struct {
		string name;
		int    op;
		int    adr;
		int    dat;
		int    exp;
		int    mask;
	} row_t;

	logic                    clk, rst_n;
	logic                    wb_cyc, wb_stb, wb_we, wb_ack, irq_ack, irq_req;
	logic [`AVR_ADDR_W-1:0]  wb_adr;
	logic [`AVR_DATA_W-1:0]  wb_wdat, wb_rdat;
	logic [`AVR_PORTB_W-1:0] pinb;
	logic [`AVR_PORTC_W-1:0] pinc;
	logic [`AVR_PORTD_W-1:0] pind;
	logic [`AVR_PORTE_W-1:0] pine;
	logic [`AVR_VEC_W-1:0]   irq_vec;
	port_pads_t              padsb, padsc, padsd, padse;
	row_t                    rows[$];
	int                      limit = 0;
	string                   pnames[4] = '{"b", "c", "d", "e"};

	avr_io_top dut0 (
		.clk(clk), .rst_n_i(rst_n), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
		.wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_wdat), .wb_ack_o(wb_ack),
		.wb_dat_o(wb_rdat), .irq_ack_i(irq_ack), .pinb_i(pinb), .pinc_i(pinc),
		.pind_i(pind), .pine_i(pine), .padsb_o(padsb), .padsc_o(padsc),
		.padsd_o(padsd), .padse_o(padse), .irq_req_o(irq_req), .irq_vec_o(irq_vec)
	);

	io_checker chk0 (
		.clk(clk), .wb_ack_i(wb_ack), .wb_dat_i(wb_rdat), .irq_req_i(irq_req),
		.irq_vec_i(irq_vec), .padsb_i(padsb), .padsc_i(padsc), .padsd_i(padsd),
		.padse_i(padse)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic add(input string name, input int op, input int adr, input int dat,
		input int exp, input int mask);
		row_t r;
		r = '{name, op, adr, dat, exp, mask};
		rows.push_back(r);
	endtask

	function automatic int pin_adr(input int p);
		case (p)
			0:       return int'(`AVR_PINB_ADR);
			1:       return int'(`AVR_PINC_ADR);
			2:       return int'(`AVR_PIND_ADR);
			default: return int'(`AVR_PINE_ADR);
		endcase
	endfunction

	function automatic int port_mask(input int p);
		case (p)
			0:       return (1 << `AVR_PORTB_W) - 1;
			1:       return (1 << `AVR_PORTC_W) - 1;
			2:       return (1 << `AVR_PORTD_W) - 1;
			default: return (1 << `AVR_PORTE_W) - 1;
		endcase
	endfunction

	task automatic build_table();
		int a, m, d, v, t, r;
		for (int p = 0; p < 4; p++) begin
			a = pin_adr(p);
			add({"reset_ddr", pnames[p]}, OP_RD, a + 1, 0, 0, 'hFF);
			add({"reset_port", pnames[p]}, OP_RD, a + 2, 0, 0, 'hFF);
			add({"reset_pads", pnames[p]}, OP_PAD, p, 0, 0, 0);
		end
		add("reset_tifr0", OP_RD, `AVR_TIFR0_ADR, 0, 0, 'hFF);
		add("reset_eifr", OP_RD, `AVR_EIFR_ADR, 0, 0, 'hFF);
		add("reset_tcnt0", OP_RD, `AVR_TCNT0_ADR, 0, 0, 'hFF);
		add("reset_irq", OP_IRQ, 0, 0, 0, 0);
		for (int p = 0; p < 4; p++) begin
			a = pin_adr(p);
			m = port_mask(p);
			d = int'($urandom) & m;
			v = int'($urandom) & m;
			t = int'($urandom) & m;
			r = int'($urandom) & m;
			add("", OP_WR, a + 1, d, 0, 0);
			add("", OP_WR, a + 2, v, 0, 0);
			add({"pads", pnames[p]}, OP_PAD, p, 0, (d << 16) | (v << 8) | (v & ~d), 0);
			add({"ddr", pnames[p]}, OP_RD, a + 1, 0, d, 'hFF);
			add("", OP_WR, a, t, 0, 0);
			add({"toggle", pnames[p]}, OP_RD, a + 2, 0, v ^ t, 'hFF);
			add("", OP_PIN, p, r, 0, 0);
			add("", OP_WAIT, 0, 3, 0, 0);
			add({"pin", pnames[p]}, OP_RD, a, 0, r, 'hFF);
		end
		// INT0 on rising edge of PD2
		add("", OP_PIN, 2, 0, 0, 0);
		add("", OP_WAIT, 0, 3, 0, 0);
		add("", OP_WR, `AVR_EICRA_ADR, 'h03, 0, 0);
		add("", OP_WR, `AVR_EIMSK_ADR, 'h01, 0, 0);
		add("", OP_PIN, 2, 'h04, 0, 0);
		add("", OP_WAIT, 0, 4, 0, 0);
		add("int0_flag", OP_RD, `AVR_EIFR_ADR, 0, 1, 'hFF);
		add("int0_ack", OP_ACK, 0, 0, `AVR_VEC_INT0, 0);
		add("int0_clear", OP_IRQ, 0, 0, 0, 0);
		add("int0_flag_clr", OP_RD, `AVR_EIFR_ADR, 0, 0, 'hFF);
		add("", OP_PIN, 2, 0, 0, 0);
		add("", OP_WAIT, 0, 4, 0, 0);
		add("int0_fall", OP_RD, `AVR_EIFR_ADR, 0, 0, 'hFF);
		add("int0_fall_irq", OP_IRQ, 0, 0, 0, 0);
		// Timer0 CTC at TOP 20, then normal mode
		add("", OP_WR, `AVR_OCR0A_ADR, 20, 0, 0);
		add("", OP_WR, `AVR_TCCR0A_ADR, 'h02, 0, 0);
		add("", OP_WR, `AVR_TCCR0B_ADR, 'h01, 0, 0);
		for (int i = 0; i < 3; i++) begin
			add("", OP_WAIT, 0, 17 + 6 * i, 0, 0);
			add($sformatf("ctc_cnt%0d", i), OP_RNG, `AVR_TCNT0_ADR, 0, 0, 20);
		end
		add("ctc_ocf0a", OP_RD, `AVR_TIFR0_ADR, 0, 'h02, 'h02);
		add("", OP_WR, `AVR_TCCR0A_ADR, 0, 0, 0);
		add("", OP_WR, `AVR_TIFR0_ADR, 'h03, 0, 0);
		add("", OP_WR, `AVR_TCNT0_ADR, 0, 0, 0);
		add("ovf_early", OP_RD, `AVR_TIFR0_ADR, 0, 0, 'h01);
		add("", OP_WAIT, 0, 300, 0, 0);
		add("ovf_tov0", OP_RD, `AVR_TIFR0_ADR, 0, 1, 'h01);
		add("", OP_WR, `AVR_TCCR0B_ADR, 0, 0, 0);
		add("", OP_WR, `AVR_TIFR0_ADR, 'h03, 0, 0);
		// INT1 and overflow pending together
		add("", OP_WR, `AVR_EICRA_ADR, 'h0F, 0, 0);
		add("", OP_WR, `AVR_EIMSK_ADR, 'h03, 0, 0);
		add("", OP_WR, `AVR_TIMSK0_ADR, 'h01, 0, 0);
		add("", OP_WR, `AVR_TCNT0_ADR, 'hFF, 0, 0);
		add("", OP_WR, `AVR_TCCR0B_ADR, 'h01, 0, 0);
		add("", OP_WR, `AVR_TCCR0B_ADR, 0, 0, 0);
		add("", OP_PIN, 2, 'h08, 0, 0);
		add("", OP_WAIT, 0, 4, 0, 0);
		add("prio_int1", OP_ACK, 0, 0, `AVR_VEC_INT1, 0);
		add("prio_ovf", OP_ACK, 0, 0, `AVR_VEC_T0_OVF, 0);
		add("prio_idle", OP_IRQ, 0, 0, 0, 0);
		// Prescaler reset with divide by 64
		add("", OP_WR, `AVR_TCNT0_ADR, 0, 0, 0);
		add("", OP_WR, `AVR_GTCCR_ADR, 1 << `AVR_PSRSYNC_BIT, 0, 0);
		add("", OP_WR, `AVR_TCCR0B_ADR, 'h03, 0, 0);
		add("", OP_WAIT, 0, 640, 0, 0);
		add("psr_tcnt0", OP_RNG, `AVR_TCNT0_ADR, 0, 9, 11);
	endtask

	task automatic bus_access(input bit we, input int adr, input int dat);
		int n;
		wb_cyc  = 1'b1;
		wb_stb  = 1'b1;
		wb_we   = we;
		wb_adr  = `AVR_ADDR_W'(adr);
		wb_wdat = `AVR_DATA_W'(dat);
		n       = 0;
		forever begin
			@(posedge clk);
			#1;
			n++;
			if (wb_ack)
				break;
			if (n > 10) begin
				chk0.note_error($sformatf("no bus ack for address 0x%0h", adr));
				break;
			end
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(posedge clk);  // Checker compares during the ack cycle
		#1;
	endtask

	task automatic run_row(input row_t r);
		case (r.op)
			OP_WR:  bus_access(1'b1, r.adr, r.dat);
			OP_RD: begin
				chk0.expect_read(r.name, r.exp, r.mask);
				bus_access(1'b0, r.adr, 0);
			end
			OP_RNG: begin
				chk0.expect_range(r.name, r.exp, r.mask);
				bus_access(1'b0, r.adr, 0);
			end
			OP_PIN: begin
				case (r.adr)
					0:       pinb = `AVR_PORTB_W'(r.dat);
					1:       pinc = `AVR_PORTC_W'(r.dat);
					2:       pind = `AVR_PORTD_W'(r.dat);
					default: pine = `AVR_PORTE_W'(r.dat);
				endcase
			end
			OP_WAIT: begin
				repeat (r.dat) @(posedge clk);
				#1;
			end
			OP_ACK: begin
				chk0.check_irq(r.name, 1, r.exp);
				irq_ack = 1'b1;
				@(posedge clk);
				#1;
				irq_ack = 1'b0;
			end
			OP_IRQ:  chk0.check_irq(r.name, 0, 0);
			default: chk0.check_pads(r.name, r.adr, r.exp);
		endcase
	endtask

	initial begin
		rst_n   = 1'b0;
		wb_cyc  = 1'b0;
		wb_stb  = 1'b0;
		wb_we   = 1'b0;
		wb_adr  = '0;
		wb_wdat = '0;
		irq_ack = 1'b0;
		pinb    = '0;
		pinc    = '0;
		pind    = '0;
		pine    = '0;
		void'($urandom(32'h9247));
		build_table();
		foreach (rows[i])
			limit += (rows[i].op == OP_WAIT ? rows[i].dat : 0) + 20;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		foreach (rows[i])
			run_row(rows[i]);
		chk0.report();
		if (chk0.fail_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		wait (limit > 0);
		repeat (limit + 10) @(posedge clk);
		$display("Watchdog expired after %0d cycles, tests did not finish", limit);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+src
src/avr_io_pkg.sv
src/io_bus_bridge.sv
src/gpio_port.sv
src/timer0_prescaler.sv
src/timer0.sv
src/ext_int.sv
src/irq_vector_arb.sv
src/avr_io_top.sv
verif/io_checker.sv
verif/tb_avr_io.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Isrc
TOP       ?= tb_avr_io
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Isrc --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
